// ==== filelist.f ====
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_pointers.sv
hdl/rob_entry_table.sv
hdl/rob_data_bank.sv
hdl/rob_retire.sv
hdl/rob_top.sv
sim/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ROB testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module rob_tb \
    -o rob_sim

out="$(./obj_dir/rob_sim)"
echo "$out"

if grep -qx "TESTBENCH PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== sim/rob_stimulus.txt ====
# C a0 valid dest lreg preg ppreg | a1 same | u0 valid ticket exc data | u1 same | flush ticket full name
# E ticket flushed write_valid lreg preg ppreg data, in program order
C 1 1 01 11 21 1 1 02 12 22 0 0 0 00000000 0 0 0 00000000 0 0 0 in_order
C 1 1 03 13 23 1 1 04 14 24 0 0 0 00000000 0 0 0 00000000 0 0 0 in_order
C 0 0 00 00 00 0 0 00 00 00 1 3 0 000000a3 0 0 0 00000000 0 0 0 in_order
C 0 0 00 00 00 0 0 00 00 00 1 2 0 000000a2 0 0 0 00000000 0 0 0 in_order
C 0 0 00 00 00 0 0 00 00 00 1 1 0 000000a1 0 0 0 00000000 0 0 0 in_order
C 0 0 00 00 00 0 0 00 00 00 1 0 0 000000a0 0 0 0 00000000 0 0 0 in_order
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 in_order
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 in_order
E 0 0 1 01 11 21 000000a0
E 1 0 1 02 12 22 000000a1
E 2 0 1 03 13 23 000000a2
E 3 0 1 04 14 24 000000a3
C 1 1 05 15 25 1 0 06 16 26 0 0 0 00000000 0 0 0 00000000 0 0 0 dual_retire
C 0 0 00 00 00 0 0 00 00 00 1 4 0 000000b4 1 5 0 000000b5 0 0 0 dual_retire
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 dual_retire
E 4 0 1 05 15 25 000000b4
E 5 0 0 06 16 26 000000b5
C 1 0 07 17 27 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 dest_write
C 1 1 08 18 28 0 0 00 00 00 1 6 0 000000c6 0 0 0 00000000 0 0 0 dest_write
C 0 0 00 00 00 0 0 00 00 00 1 7 0 000000c7 0 0 0 00000000 0 0 0 dest_write
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 dest_write
E 6 0 0 07 17 27 000000c6
E 7 0 1 08 18 28 000000c7
C 1 1 09 19 29 1 1 0a 1a 2a 0 0 0 00000000 0 0 0 00000000 0 0 0 flush
C 1 1 0b 1b 2b 1 1 0c 1c 2c 0 0 0 00000000 0 0 0 00000000 0 0 0 flush
C 1 1 0d 1d 2d 0 0 00 00 00 1 1 0 000000d1 0 0 0 00000000 1 1 0 flush
C 0 0 00 00 00 0 0 00 00 00 1 0 0 000000d0 0 0 0 00000000 0 0 0 flush
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 flush
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 flush
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 0 flush
E 0 0 1 09 19 29 000000d0
E 1 0 1 0a 1a 2a 000000d1
E 2 1 0 0b 1b 2b 00000000
E 3 1 0 0c 1c 2c 00000000
E 4 1 0 0d 1d 2d 00000000
C 1 1 0e 1e 2e 1 1 0f 1f 2f 0 0 0 00000000 0 0 0 00000000 0 0 0 full_stall
C 1 1 10 20 30 1 1 11 21 31 0 0 0 00000000 0 0 0 00000000 0 0 0 full_stall
C 1 1 12 22 32 1 1 13 23 33 0 0 0 00000000 0 0 0 00000000 0 0 0 full_stall
C 1 1 14 24 34 1 1 15 25 35 0 0 0 00000000 0 0 0 00000000 0 0 1 full_stall
C 0 0 00 00 00 0 0 00 00 00 1 5 1 000000e5 1 6 0 000000e6 0 0 1 full_stall
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 1 full_stall
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 1 full_stall
C 0 0 00 00 00 0 0 00 00 00 0 0 0 00000000 0 0 0 00000000 0 0 1 full_stall

// ==== sim/rob_tb.sv ====
// ****************************************
// Testbench for the reorder buffer
// Runs from the project root, reads
// sim/rob_stimulus.txt
// Data of flushed commits is not compared
// ****************************************
`default_nettype none

`include "rob_consts.svh"

module rob_tb import rob_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk;
    logic                           rst_n;
    alloc_req_t [1:0]               alloc;
    fu_update_t [`ROB_FU_PORTS-1:0] fu_update;
    logic                           flush_valid;
    rob_ticket_t                    flush_ticket;
    rob_status_t                    status;
    commit_t [1:0]                  commit;

    // Stimulus table, one element per cycle
    alloc_req_t [1:0]               stim_alloc [$];
    fu_update_t [`ROB_FU_PORTS-1:0] stim_upd [$];
    logic                           stim_flush [$];
    rob_ticket_t                    stim_ft [$];
    logic                           stim_full [$];
    logic [8*24-1:0]                stim_name [$];
    commit_t                        exp_q [$];

    logic [8*24-1:0] cur_name;
    logic            stim_ok;
    logic            running = 1'b0;
    logic            chk_full = 1'b0;
    rob_ticket_t     exp_ticket = '0;
    int              cycles = 0;
    int              limit = 100000;
    int              errors = 0;
    int              test_err = 0;
    int              tests = 0;
    int              failed_tests = 0;
    int              checks = 0;

    rob_top rob_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .fu_update    (fu_update),
        .flush_valid  (flush_valid),
        .flush_ticket (flush_ticket),
        .status       (status),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic note_error();
        errors++;
        test_err++;
    endtask

    task automatic finish_test();
        tests++;
        if (test_err == 0) begin
            $display("test %0s: ok", cur_name);
        end else begin
            $display("test %0s: %0d errors", cur_name, test_err);
            failed_tests++;
        end
        test_err = 0;
    endtask

    task automatic load_stimulus(output logic ok);
        int                             fd;
        int                             code;
        int                             v [21];
        logic [8*24-1:0]                tag;
        logic [8*24-1:0]                nm;
        string                          rest;
        alloc_req_t [1:0]               al;
        fu_update_t [`ROB_FU_PORTS-1:0] up;
        commit_t                        c;
        fd = $fopen("sim/rob_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    break;
                end
                if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                   v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17]);
                    code = $fscanf(fd, "%h %h %h %s", v[18], v[19], v[20], nm);
                    for (int k = 0; k < 2; k++) begin
                        al[k].valid      = (v[5*k] != 0);
                        al[k].valid_dest = (v[5*k+1] != 0);
                        al[k].lreg       = areg_t'(v[5*k+2]);
                        al[k].preg       = preg_t'(v[5*k+3]);
                        al[k].ppreg      = preg_t'(v[5*k+4]);
                        up[k].valid      = (v[10+4*k] != 0);
                        up[k].ticket     = rob_ticket_t'(v[11+4*k]);
                        up[k].exception  = (v[12+4*k] != 0);
                        up[k].data       = rob_data_t'(v[13+4*k]);
                    end
                    stim_alloc.push_back(al);
                    stim_upd.push_back(up);
                    stim_flush.push_back(v[18] != 0);
                    stim_ft.push_back(rob_ticket_t'(v[19]));
                    stim_full.push_back(v[20] != 0);
                    stim_name.push_back(nm);
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h",
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    c              = '0;
                    c.commit_valid = 1'b1;
                    c.ticket       = rob_ticket_t'(v[0]);
                    c.flushed      = (v[1] != 0);
                    c.write_valid  = (v[2] != 0);
                    c.lreg         = areg_t'(v[3]);
                    c.preg         = preg_t'(v[4]);
                    c.ppreg        = preg_t'(v[5]);
                    c.data         = rob_data_t'(v[6]);
                    exp_q.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_commit(input commit_t got);
        commit_t want;
        commit_t seen;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("Commit of ticket %0d in test %0s was not expected", got.ticket, cur_name);
            note_error();
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            seen = got;
            if (want.flushed) begin
                want.data = '0;
                seen.data = '0;
            end
            assert (seen == want) else begin
                $display("CHECK FAILED %0s expected %h actual %h", cur_name, want, seen);
                note_error();
            end
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (running) begin
            assert (commit[0].commit_valid || !commit[1].commit_valid) else begin
                $display("Port 1 committed while port 0 was idle in test %0s", cur_name);
                note_error();
            end
            if (alloc[0].valid) begin
                checks++;
                assert (status.next_ticket == exp_ticket) else begin
                    $display("CHECK FAILED %0s expected %h actual %h",
                             cur_name, exp_ticket, status.next_ticket);
                    note_error();
                end
            end
            // A full ROB has no two free entries either
            if (chk_full) begin
                checks++;
                assert ({status.full, status.two_free} == 2'b10) else begin
                    $display("CHECK FAILED %0s expected %b actual %b",
                             cur_name, 2'b10, {status.full, status.two_free});
                    note_error();
                end
            end
            for (int p = 0; p < 2; p++) begin
                if (commit[p].commit_valid) begin
                    compare_commit(commit[p]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d expected commits never appeared",
                     cycles, exp_q.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst_n        = 1'b0;
        alloc        = '0;
        fu_update    = '0;
        flush_valid  = 1'b0;
        flush_ticket = '0;
        cur_name     = '0;
        load_stimulus(stim_ok);
        if (!stim_ok) begin
            $display("Cannot open the stimulus file");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            limit = stim_alloc.size() + 64;
            repeat (2) @(posedge clk);
            #2 rst_n = 1'b1;
            for (int n = 0; n < stim_alloc.size(); n++) begin
                @(posedge clk);
                #2;
                if (n != 0 && stim_name[n] != cur_name) begin
                    finish_test();
                end
                // Tail model, tickets wrap at the entry count
                if (n != 0) begin
                    exp_ticket = exp_ticket + rob_ticket_t'(stim_alloc[n-1][0].valid)
                                            + rob_ticket_t'(stim_alloc[n-1][1].valid);
                end
                cur_name     = stim_name[n];
                alloc        = stim_alloc[n];
                fu_update    = stim_upd[n];
                flush_valid  = stim_flush[n];
                flush_ticket = stim_ft[n];
                chk_full     = stim_full[n];
                running      = 1'b1;
            end
            @(posedge clk);
            #2;
            alloc       = '0;
            fu_update   = '0;
            flush_valid = 1'b0;
            chk_full    = 1'b0;
            while (exp_q.size() != 0) begin
                @(posedge clk);
            end
            @(posedge clk);
            running = 1'b0;
            finish_test();
            $display("%0d tests, %0d failed, %0d checks, %0d errors",
                     tests, failed_tests, checks, errors);
            if (errors == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_top.sv ====
// ****************************************
// Reorder buffer, dual allocate and
// dual retire
// Port 0 of alloc and commit is older
// No handshakes, all inputs are strobes
// ****************************************
`default_nettype none

`include "rob_consts.svh"

module rob_top import rob_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  alloc_req_t [1:0]               alloc,
    input  fu_update_t [`ROB_FU_PORTS-1:0] fu_update,
    input  logic                           flush_valid,
    input  rob_ticket_t                    flush_ticket,
    output rob_status_t                    status,
    output commit_t [1:0]                  commit
);

    rob_ticket_t head;
    rob_ticket_t tail;
    logic        commit_one;
    logic        commit_two;
    rob_entry_t  head_entry;
    rob_entry_t  next_entry;
    rob_data_t   head_data;
    rob_data_t   next_data;

    rob_pointers rob_pointers_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .commit_one (commit_one),
        .commit_two (commit_two),
        .head       (head),
        .tail       (tail),
        .status     (status)
    );

    rob_entry_table rob_entry_table_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .fu_update    (fu_update),
        .flush_valid  (flush_valid),
        .flush_ticket (flush_ticket),
        .head         (head),
        .tail         (tail),
        .commit_one   (commit_one),
        .commit_two   (commit_two),
        .head_entry   (head_entry),
        .next_entry   (next_entry)
    );

    rob_data_bank rob_data_bank_i (
        .clk       (clk),
        .fu_update (fu_update),
        .head      (head),
        .head_data (head_data),
        .next_data (next_data)
    );

    rob_retire rob_retire_i (
        .head       (head),
        .head_entry (head_entry),
        .next_entry (next_entry),
        .head_data  (head_data),
        .next_data  (next_data),
        .commit_one (commit_one),
        .commit_two (commit_two),
        .commit     (commit)
    );

endmodule

`default_nettype wire

// ==== hdl/rob_retire.sv ====
// ****************************************
// Commit decision for the two oldest
// entries, purely combinational
// An excepting head that is not flushed
// blocks retirement
// ****************************************
`default_nettype none

`include "rob_consts.svh"

module rob_retire import rob_pkg::*; (
    input  rob_ticket_t   head,
    input  rob_entry_t    head_entry,
    input  rob_entry_t    next_entry,
    input  rob_data_t     head_data,
    input  rob_data_t     next_data,
    output logic          commit_one,
    output logic          commit_two,
    output commit_t [1:0] commit
);

    rob_entry_t  ent [2];
    rob_data_t   dat [2];
    rob_ticket_t tkt [2];
    logic        fire [2];

    // Completed cleanly, or flushed and done regardless of its state
    function automatic logic can_retire(input rob_entry_t e);
        logic clean;
        clean = e.valid & ~e.pending & ~e.exception;
        return clean | (e.valid & e.flushed);
    endfunction

    assign commit_one = can_retire(head_entry);
    assign commit_two = commit_one & can_retire(next_entry);

    always_comb begin
        ent[0]  = head_entry;
        ent[1]  = next_entry;
        dat[0]  = head_data;
        dat[1]  = next_data;
        tkt[0]  = head;
        tkt[1]  = head + rob_ticket_t'(1);
        fire[0] = commit_one;
        fire[1] = commit_two;
        for (int p = 0; p < 2; p++) begin
            commit[p].commit_valid = fire[p];
            // Flushed entries never reach the register file
            commit[p].write_valid  = fire[p] & ent[p].valid_dest & ~ent[p].flushed;
            commit[p].flushed      = ent[p].flushed;
            commit[p].ticket       = tkt[p];
            commit[p].lreg         = ent[p].lreg;
            commit[p].preg         = ent[p].preg;
            commit[p].ppreg        = ent[p].ppreg;
            commit[p].data         = dat[p];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_data_bank.sv ====
// ****************************************
// Result storage of the ROB, no reset
// Two updates to one ticket in a cycle
// are not expected, the higher port wins
// ****************************************
`default_nettype none

`include "rob_consts.svh"

module rob_data_bank import rob_pkg::*; (
    input  logic                           clk,
    input  fu_update_t [`ROB_FU_PORTS-1:0] fu_update,
    input  rob_ticket_t                    head,
    output rob_data_t                      head_data,
    output rob_data_t                      next_data
);

    rob_data_t   mem [`ROB_ENTRIES];
    rob_ticket_t head_plus;

    // Every functional unit has its own write port
    always_ff @(posedge clk) begin
        for (int j = 0; j < `ROB_FU_PORTS; j++) begin
            if (fu_update[j].valid) begin
                mem[fu_update[j].ticket] <= fu_update[j].data;
            end
        end
    end

    assign head_plus = head + rob_ticket_t'(1);

    // Read ports for the two oldest entries
    assign head_data = mem[head];
    assign next_data = mem[head_plus];

endmodule

`default_nettype wire

// ==== hdl/rob_entry_table.sv ====
// ****************************************
// Per-entry control fields of the ROB
// Only valid is reset, the other fields
// are written at allocation
// ****************************************
`default_nettype none

`include "rob_consts.svh"

module rob_entry_table import rob_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  alloc_req_t [1:0]               alloc,
    input  fu_update_t [`ROB_FU_PORTS-1:0] fu_update,
    input  logic                           flush_valid,
    input  rob_ticket_t                    flush_ticket,
    input  rob_ticket_t                    head,
    input  rob_ticket_t                    tail,
    input  logic                           commit_one,
    input  logic                           commit_two,
    output rob_entry_t                     head_entry,
    output rob_entry_t                     next_entry
);

    logic [`ROB_ENTRIES-1:0] valid_q;
    logic [`ROB_ENTRIES-1:0] pending_q;
    logic [`ROB_ENTRIES-1:0] flushed_q;
    logic [`ROB_ENTRIES-1:0] exc_q;
    logic [`ROB_ENTRIES-1:0] vdest_q;
    areg_t                   lreg_q  [`ROB_ENTRIES];
    preg_t                   preg_q  [`ROB_ENTRIES];
    preg_t                   ppreg_q [`ROB_ENTRIES];

    rob_ticket_t             head_plus;
    rob_ticket_t             slot [2];
    logic [`ROB_ENTRIES-1:0] alloc_hit [2];
    logic [`ROB_ENTRIES-1:0] flush_mask;

    assign head_plus = head + rob_ticket_t'(1);

    // Request 1 lands behind request 0 only when both are valid
    always_comb begin
        slot[0] = tail;
        slot[1] = alloc[0].valid ? tail + rob_ticket_t'(1) : tail;
        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < `ROB_ENTRIES; i++) begin
                alloc_hit[k][i] = alloc[k].valid && (slot[k] == rob_ticket_t'(i));
            end
        end
    end

    // Walk from the entry after the flush ticket up to, not including, head
    always_comb begin
        rob_ticket_t idx;
        logic        stop;
        flush_mask = '0;
        idx        = flush_ticket + rob_ticket_t'(1);
        stop       = 1'b0;
        for (int i = 0; i < `ROB_ENTRIES - 1; i++) begin
            if (idx == head) begin
                stop = 1'b1;
            end
            if (!stop) begin
                flush_mask[idx] = flush_valid;
            end
            idx = idx + rob_ticket_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            if (flush_mask[i]) begin
                flushed_q[i] <= 1'b1;
            end
            for (int j = 0; j < `ROB_FU_PORTS; j++) begin
                if (fu_update[j].valid && (fu_update[j].ticket == rob_ticket_t'(i))) begin
                    pending_q[i] <= 1'b0;
                    exc_q[i]     <= fu_update[j].exception;
                end
            end
            // A fresh entry overrides anything aimed at the old occupant
            for (int k = 0; k < 2; k++) begin
                if (alloc_hit[k][i]) begin
                    pending_q[i] <= 1'b1;
                    exc_q[i]     <= 1'b0;
                    flushed_q[i] <= flush_valid;
                    vdest_q[i]   <= alloc[k].valid_dest;
                    lreg_q[i]    <= alloc[k].lreg;
                    preg_q[i]    <= alloc[k].preg;
                    ppreg_q[i]   <= alloc[k].ppreg;
                end
            end
        end
    end

    // Retirement clears, allocation sets
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_q & ~({`ROB_ENTRIES{commit_one}} & (`ROB_ENTRIES'(1) << head))
                               & ~({`ROB_ENTRIES{commit_two}} & (`ROB_ENTRIES'(1) << head_plus))
                               | alloc_hit[0] | alloc_hit[1];
        end
    end

    always_comb begin
        head_entry = '{valid_q[head], pending_q[head], flushed_q[head], exc_q[head],
                       vdest_q[head], lreg_q[head], preg_q[head], ppreg_q[head]};
        next_entry = '{valid_q[head_plus], pending_q[head_plus], flushed_q[head_plus],
                       exc_q[head_plus], vdest_q[head_plus], lreg_q[head_plus],
                       preg_q[head_plus], ppreg_q[head_plus]};
    end

endmodule

`default_nettype wire

// ==== hdl/rob_pointers.sv ====
// ****************************************
// Head, tail and occupancy of the ROB
// Issue must respect full and two_free,
// overflow is not detected here
// ****************************************
`default_nettype none

`include "rob_consts.svh"

module rob_pointers import rob_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  alloc_req_t [1:0] alloc,
    input  logic             commit_one,
    input  logic             commit_two,
    output rob_ticket_t      head,
    output rob_ticket_t      tail,
    output rob_status_t      status
);

    logic [1:0] alloc_cnt;
    logic [1:0] commit_cnt;
    rob_count_t count;
    rob_count_t count_next;

    // Number of entries taken and released this cycle
    always_comb begin
        alloc_cnt = {1'b0, alloc[0].valid} + {1'b0, alloc[1].valid};
        if (commit_two) begin
            commit_cnt = 2'd2;
        end else if (commit_one) begin
            commit_cnt = 2'd1;
        end else begin
            commit_cnt = 2'd0;
        end
    end

    assign count_next = count + rob_count_t'(alloc_cnt) - rob_count_t'(commit_cnt);

    // Status looks at occupancy after this cycle
    always_comb begin
        status.next_ticket = tail;
        status.full        = (count_next == rob_count_t'(`ROB_ENTRIES));
        status.two_free    = (count_next < rob_count_t'(`ROB_ENTRIES - 1));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Tickets wrap naturally at the entry count
            head  <= head + rob_ticket_t'(commit_cnt);
            tail  <= tail + rob_ticket_t'(alloc_cnt);
            count <= count_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_pkg.sv ====
// ****************************************
// Types shared by the reorder buffer blocks
// Widths come from rob_consts.svh
// ****************************************
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

    typedef logic [`ROB_TICKET_BITS-1:0] rob_ticket_t;
    typedef logic [`ROB_TICKET_BITS:0]   rob_count_t;
    typedef logic [`ROB_AREG_BITS-1:0]   areg_t;
    typedef logic [`ROB_PREG_BITS-1:0]   preg_t;
    typedef logic [`ROB_DATA_BITS-1:0]   rob_data_t;

    // One instruction from issue
    typedef struct packed {
        logic  valid;
        logic  valid_dest;
        areg_t lreg;
        preg_t preg;
        preg_t ppreg;
    } alloc_req_t;

    // Completion from a functional unit
    typedef struct packed {
        logic        valid;
        rob_ticket_t ticket;
        logic        exception;
        rob_data_t   data;
    } fu_update_t;

    // Retirement towards the register file
    typedef struct packed {
        logic        commit_valid;
        logic        write_valid;
        logic        flushed;
        rob_ticket_t ticket;
        areg_t       lreg;
        preg_t       preg;
        preg_t       ppreg;
        rob_data_t   data;
    } commit_t;

    typedef struct packed {
        rob_ticket_t next_ticket;
        logic        full;
        logic        two_free;
    } rob_status_t;

    // Control fields of one entry, as seen by retire
    typedef struct packed {
        logic  valid;
        logic  pending;
        logic  flushed;
        logic  exception;
        logic  valid_dest;
        areg_t lreg;
        preg_t preg;
        preg_t ppreg;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== hdl/rob_consts.svh ====
// ****************************************
// Sizing of the reorder buffer
// ROB_TICKET_BITS must be log2 of ROB_ENTRIES
// Only two allocation and two commit ports
// ****************************************
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

`define ROB_ENTRIES     8
`define ROB_TICKET_BITS 3
`define ROB_FU_PORTS    2

// Register index and result widths
`define ROB_AREG_BITS   5
`define ROB_PREG_BITS   6
`define ROB_DATA_BITS   32

`endif
